//--- common/decode_defines.svh
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// datapath and pc width
`define WORD_W 32

// architectural register index
`define REG_W 5

// completion buffer index width
`define ROB_IDX_W 6

// arith, mul, div, lsu
`define NUM_FU 4

// writeback reservation length, bit i is the cycle i from now
`define WB_DEPTH 18

// result delay per unit in cycles
`define ALU_WB_SLOT 0
`define MUL_WB_SLOT 3
`define DIV_WB_SLOT 17

`endif

//--- common/decode_pkg.sv
package decode_pkg;

  // rv32 major opcodes handled by this decode stage
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111
  } opcode_e;

  // functional units, value doubles as the dispatch slot index
  typedef enum logic [1:0] {
    FU_ARITH = 2'd0,
    FU_MUL   = 2'd1,
    FU_DIV   = 2'd2,
    FU_LSU   = 2'd3
  } fu_type_e;

  // alu operations
  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    AND  = 4'd2,
    OR   = 4'd3,
    XOR  = 4'd4,
    SLL  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    SLT  = 4'd8,
    SLTU = 4'd9
  } alu_op_e;

  // operand a source
  typedef enum logic [1:0] {
    SRC_A_RS1  = 2'd0,
    SRC_A_PC   = 2'd1,
    SRC_A_ZERO = 2'd2
  } src_a_e;

  // operand b source
  typedef enum logic [1:0] {
    SRC_B_RS2   = 2'd0,
    SRC_B_IMM_I = 2'd1,
    SRC_B_IMM_S = 2'd2,
    SRC_B_IMM_U = 2'd3
  } src_b_e;

endpackage

//--- decode_stage.f
+incdir+common
common/decode_pkg.sv
src/instr_decoder.sv
src/operand_latch.sv
dispatch/fu_dispatch_slot.sv
dispatch/wb_port_scheduler.sv
src/decode_stage.sv
test/decode_stage_tb.sv

//--- dispatch/fu_dispatch_slot.sv
`timescale 1ns/1ns
`include "decode_defines.svh"

module fu_dispatch_slot (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  flush,
  input  logic                  stall_ex,
  input  logic                  unit_stall,
  input  logic                  sel,
  input  logic [`REG_W-1:0]     rd,
  input  logic                  wen,
  input  logic [2:0]            funct3,
  input  logic [`ROB_IDX_W-1:0] rob_index,
  output logic                  ena,
  output logic [`REG_W-1:0]     rd_q,
  output logic                  wen_q,
  output logic [2:0]            funct3_q,
  output logic [`ROB_IDX_W-1:0] rob_index_q
);

  logic advance;

  // slot moves only when neither the whole execute side nor this unit is stalled
  assign advance = !stall_ex && !unit_stall;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ena   <= 1'b0;
      wen_q <= 1'b0;
    end else if (flush) begin
      ena   <= 1'b0;
      wen_q <= 1'b0;
    end else if (advance) begin
      // bubble when not selected
      ena   <= sel;
      wen_q <= sel & wen;
    end
  end

  always_ff @(posedge CLK) begin
    if (flush) begin
      rd_q        <= '0;
      funct3_q    <= '0;
      rob_index_q <= '0;
    end else if (advance && sel) begin
      rd_q        <= rd;
      funct3_q    <= funct3;
      rob_index_q <= rob_index;
    end
  end

  // nothing survives a flush into execute
  a_flush_kills: assert property (@(posedge CLK) disable iff (!nRST) flush |=> !ena);

endmodule

//--- dispatch/wb_port_scheduler.sv
`timescale 1ns/1ns
`include "decode_defines.svh"

module wb_port_scheduler (
  input  logic                 CLK,
  input  logic                 nRST,
  input  decode_pkg::fu_type_e fu_type,
  input  logic [`NUM_FU-1:0]   fu_sel,
  input  logic                 div_special,
  output logic                 wb_port_conflict
);
  import decode_pkg::*;

  // bit i set means the write port is taken i cycles from now
  logic [`WB_DEPTH-1:0] res;
  logic [`WB_DEPTH-1:0] claim;
  logic [`WB_DEPTH-1:0] next_res;
  logic                 claiming;

  // writeback cycle the presented instruction would need
  always_comb begin
    case (fu_type)
      FU_ARITH: claim = `WB_DEPTH'(1) << `ALU_WB_SLOT;
      FU_MUL:   claim = `WB_DEPTH'(1) << `MUL_WB_SLOT;
      FU_DIV: begin
        // special operands skip the iterative divide
        if (div_special) begin
          claim = `WB_DEPTH'(1) << `ALU_WB_SLOT;
        end else begin
          claim = `WB_DEPTH'(1) << `DIV_WB_SLOT;
        end
      end
      default:  claim = '0;
    endcase
  end

  // lsu has an empty claim, so it never conflicts
  assign wb_port_conflict = |(res & claim);

  // only the unit actually dispatched books its cycle
  assign claiming = fu_sel[fu_type];
  assign next_res = (res | (claiming ? claim : '0)) >> 1;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      res <= '0;
    end else begin
      res <= next_res;
    end
  end

  // decoder must hold back anything landing on a booked cycle
  a_no_double_book: assert property (@(posedge CLK) disable iff (!nRST)
    (|fu_sel) |-> ((res & claim) == '0));

endmodule

//--- run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module decode_stage_tb -f decode_stage.f \
  -o decode_stage_sim > build.log 2>&1 &&
./obj_dir/decode_stage_sim > sim.log 2>&1 ||
{ echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "^>>> PASS$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- src/decode_stage.sv
`timescale 1ns/1ns
`include "decode_defines.svh"

module decode_stage (
  input  logic                               CLK,
  input  logic                               nRST,
  input  logic [`WORD_W-1:0]                 instr,
  input  logic [`WORD_W-1:0]                 pc,
  input  logic [`WORD_W-1:0]                 rs1_data,
  input  logic [`WORD_W-1:0]                 rs2_data,
  input  logic                               rs1_bypass_ena,
  input  logic [`WORD_W-1:0]                 rs1_bypass_data,
  input  logic                               rs2_bypass_ena,
  input  logic [`WORD_W-1:0]                 rs2_bypass_data,
  input  logic [`ROB_IDX_W-1:0]              cur_tail,
  input  logic                               stall_decode,
  input  logic                               stall_ex,
  input  logic [`NUM_FU-1:0]                 fu_stall,
  input  logic                               flush,
  output logic [`REG_W-1:0]                  rs1,
  output logic [`REG_W-1:0]                  rs2,
  output logic                               rob_alloc,
  output logic                               wb_port_conflict,
  output logic [`WORD_W-1:0]                 port_a,
  output logic [`WORD_W-1:0]                 port_b,
  output logic [`WORD_W-1:0]                 store_data,
  output decode_pkg::alu_op_e                alu_op,
  output logic [`NUM_FU-1:0]                 ex_ena,
  output logic [`NUM_FU-1:0][`REG_W-1:0]     ex_rd,
  output logic [`NUM_FU-1:0]                 ex_wen,
  output logic [`NUM_FU-1:0][2:0]            ex_funct3,
  output logic [`NUM_FU-1:0][`ROB_IDX_W-1:0] ex_rob_index
);
  import decode_pkg::*;

  logic [`REG_W-1:0]  rd;
  logic [2:0]         funct3;
  logic [`WORD_W-1:0] imm_i;
  logic [`WORD_W-1:0] imm_s;
  logic [`WORD_W-1:0] imm_u;
  src_a_e             src_a_sel;
  src_b_e             src_b_sel;
  alu_op_e            alu_op_d;
  fu_type_e           fu_type;
  logic               wen;
  logic [`NUM_FU-1:0] fu_sel;
  logic               div_special;

  instr_decoder u_decoder (
    .instr(instr), .wb_port_conflict(wb_port_conflict), .stall_decode(stall_decode),
    .rs1(rs1), .rs2(rs2), .rd(rd), .funct3(funct3),
    .imm_i(imm_i), .imm_s(imm_s), .imm_u(imm_u),
    .src_a_sel(src_a_sel), .src_b_sel(src_b_sel), .alu_op(alu_op_d),
    .fu_type(fu_type), .wen(wen), .fu_sel(fu_sel), .rob_alloc(rob_alloc)
  );

  operand_latch u_operands (
    .CLK(CLK), .nRST(nRST), .flush(flush), .stall_ex(stall_ex), .pc(pc),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .rs1_bypass_ena(rs1_bypass_ena), .rs1_bypass_data(rs1_bypass_data),
    .rs2_bypass_ena(rs2_bypass_ena), .rs2_bypass_data(rs2_bypass_data),
    .src_a_sel(src_a_sel), .src_b_sel(src_b_sel),
    .imm_i(imm_i), .imm_s(imm_s), .imm_u(imm_u), .alu_op(alu_op_d),
    .div_special(div_special), .port_a(port_a), .port_b(port_b),
    .store_data(store_data), .alu_op_q(alu_op)
  );

  wb_port_scheduler u_wb_sched (
    .CLK(CLK), .nRST(nRST), .fu_type(fu_type), .fu_sel(fu_sel),
    .div_special(div_special), .wb_port_conflict(wb_port_conflict)
  );

  // one latch per unit, slot index is the unit enum
  for (genvar u = 0; u < `NUM_FU; u++) begin : slot
    localparam fu_type_e UNIT = fu_type_e'(u);
    fu_dispatch_slot u_slot (
      .CLK(CLK), .nRST(nRST), .flush(flush), .stall_ex(stall_ex),
      .unit_stall(fu_stall[UNIT]), .sel(fu_sel[UNIT]),
      .rd(rd), .wen(wen), .funct3(funct3), .rob_index(cur_tail),
      .ena(ex_ena[UNIT]), .rd_q(ex_rd[UNIT]), .wen_q(ex_wen[UNIT]),
      .funct3_q(ex_funct3[UNIT]), .rob_index_q(ex_rob_index[UNIT])
    );
  end

endmodule

//--- src/instr_decoder.sv
`timescale 1ns/1ns
`include "decode_defines.svh"

module instr_decoder (
  input  logic [`WORD_W-1:0]  instr,
  input  logic                wb_port_conflict,
  input  logic                stall_decode,
  output logic [`REG_W-1:0]   rs1,
  output logic [`REG_W-1:0]   rs2,
  output logic [`REG_W-1:0]   rd,
  output logic [2:0]          funct3,
  output logic [`WORD_W-1:0]  imm_i,
  output logic [`WORD_W-1:0]  imm_s,
  output logic [`WORD_W-1:0]  imm_u,
  output decode_pkg::src_a_e  src_a_sel,
  output decode_pkg::src_b_e  src_b_sel,
  output decode_pkg::alu_op_e alu_op,
  output decode_pkg::fu_type_e fu_type,
  output logic                wen,
  output logic [`NUM_FU-1:0]  fu_sel,
  output logic                rob_alloc
);
  import decode_pkg::*;

  opcode_e  opcode;
  logic [6:0] funct7;
  alu_op_e  alu_base;
  fu_type_e fu_raw;
  logic     legal;
  logic     dispatch;

  // fixed rv32 field positions
  assign opcode = opcode_e'(instr[6:0]);
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct7 = instr[31:25];

  // sign extended immediates
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u = {instr[31:12], 12'b0};

  // funct3 to alu op when funct7 is zero
  always_comb begin
    case (funct3)
      3'b000:  alu_base = ADD;
      3'b001:  alu_base = SLL;
      3'b010:  alu_base = SLT;
      3'b011:  alu_base = SLTU;
      3'b100:  alu_base = XOR;
      3'b101:  alu_base = SRL;
      3'b110:  alu_base = OR;
      default: alu_base = AND;
    endcase
  end

  always_comb begin
    legal     = 1'b1;
    fu_raw    = FU_ARITH;
    alu_op    = ADD;
    src_a_sel = SRC_A_RS1;
    src_b_sel = SRC_B_RS2;
    wen       = 1'b1;
    case (opcode)
      OP: begin
        if (funct7 == 7'b0000001) begin
          // m extension, funct3[2] splits mul from div/rem
          fu_raw = funct3[2] ? FU_DIV : FU_MUL;
        end else if (funct7 == 7'b0000000) begin
          alu_op = alu_base;
        end else if (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)) begin
          alu_op = funct3[2] ? SRA : SUB;
        end else begin
          legal = 1'b0;
        end
      end
      OP_IMM: begin
        // shifts take the shamt from port_b[4:0]
        src_b_sel = SRC_B_IMM_I;
        if (funct3 == 3'b001) begin
          alu_op = SLL;
          legal  = (funct7 == 7'b0000000);
        end else if (funct3 == 3'b101) begin
          alu_op = instr[30] ? SRA : SRL;
          legal  = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
        end else begin
          alu_op = alu_base;
        end
      end
      LOAD: begin
        fu_raw    = FU_LSU;
        src_b_sel = SRC_B_IMM_I;
        legal     = (funct3 != 3'b011) && (funct3 != 3'b110) && (funct3 != 3'b111);
      end
      STORE: begin
        fu_raw    = FU_LSU;
        src_b_sel = SRC_B_IMM_S;
        wen       = 1'b0;
        legal     = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b010);
      end
      LUI: begin
        src_a_sel = SRC_A_ZERO;
        src_b_sel = SRC_B_IMM_U;
      end
      AUIPC: begin
        src_a_sel = SRC_A_PC;
        src_b_sel = SRC_B_IMM_U;
      end
      default: legal = 1'b0;
    endcase
  end

  // illegal words report as lsu so they never claim the write port
  assign fu_type = legal ? fu_raw : FU_LSU;

  // one-hot dispatch strobe
  assign dispatch  = legal & ~stall_decode & ~wb_port_conflict;
  assign fu_sel    = dispatch ? (`NUM_FU'(1) << fu_type) : '0;
  assign rob_alloc = |fu_sel;

endmodule

//--- src/operand_latch.sv
`timescale 1ns/1ns
`include "decode_defines.svh"

module operand_latch (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                flush,
  input  logic                stall_ex,
  input  logic [`WORD_W-1:0]  pc,
  input  logic [`WORD_W-1:0]  rs1_data,
  input  logic [`WORD_W-1:0]  rs2_data,
  input  logic                rs1_bypass_ena,
  input  logic [`WORD_W-1:0]  rs1_bypass_data,
  input  logic                rs2_bypass_ena,
  input  logic [`WORD_W-1:0]  rs2_bypass_data,
  input  decode_pkg::src_a_e  src_a_sel,
  input  decode_pkg::src_b_e  src_b_sel,
  input  logic [`WORD_W-1:0]  imm_i,
  input  logic [`WORD_W-1:0]  imm_s,
  input  logic [`WORD_W-1:0]  imm_u,
  input  decode_pkg::alu_op_e alu_op,
  output logic                div_special,
  output logic [`WORD_W-1:0]  port_a,
  output logic [`WORD_W-1:0]  port_b,
  output logic [`WORD_W-1:0]  store_data,
  output decode_pkg::alu_op_e alu_op_q
);
  import decode_pkg::*;

  logic [`WORD_W-1:0] rs1_val;
  logic [`WORD_W-1:0] rs2_val;
  logic [`WORD_W-1:0] src_a;
  logic [`WORD_W-1:0] src_b;

  // bypass wins over the register file
  assign rs1_val = rs1_bypass_ena ? rs1_bypass_data : rs1_data;
  assign rs2_val = rs2_bypass_ena ? rs2_bypass_data : rs2_data;

  always_comb begin
    case (src_a_sel)
      SRC_A_RS1: src_a = rs1_val;
      SRC_A_PC:  src_a = pc;
      default:   src_a = '0;
    endcase
  end

  always_comb begin
    case (src_b_sel)
      SRC_B_RS2:   src_b = rs2_val;
      SRC_B_IMM_I: src_b = imm_i;
      SRC_B_IMM_S: src_b = imm_s;
      default:     src_b = imm_u;
    endcase
  end

  // overflow or divide by zero, the divider answers these in one pass
  assign div_special = (src_a == {1'b1, {(`WORD_W-1){1'b0}}}) ||
                       (src_b == '0) || (src_b == '1);

  always_ff @(posedge CLK) begin
    if (flush) begin
      port_a     <= '0;
      port_b     <= '0;
      store_data <= '0;
    end else if (!stall_ex) begin
      port_a     <= src_a;
      port_b     <= src_b;
      store_data <= rs2_val;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      alu_op_q <= ADD;
    end else if (flush) begin
      alu_op_q <= ADD;
    end else if (!stall_ex) begin
      alu_op_q <= alu_op;
    end
  end

endmodule

//--- test/decode_stage_tb.sv
`timescale 1ns/1ns
`include "decode_defines.svh"

module decode_stage_tb;
  import decode_pkg::*;

  // all tests together take well under 200 cycles
  localparam int TIMEOUT_CYCLES = 2000;

  typedef struct packed {
    logic       legal;
    fu_type_e   unit;
    logic       op_chk;
    alu_op_e    op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sd;
    logic        wen;
  } ref_t;

  logic CLK, nRST, rs1_bypass_ena, rs2_bypass_ena, stall_decode, stall_ex, flush;
  logic [31:0] instr, pc, rs1_data, rs2_data, rs1_bypass_data, rs2_bypass_data;
  logic [`ROB_IDX_W-1:0] cur_tail;
  logic [3:0] fu_stall;
  logic [4:0] rs1, rs2;
  logic rob_alloc, wb_port_conflict;
  logic [31:0] port_a, port_b, store_data;
  alu_op_e alu_op;
  logic [3:0] ex_ena, ex_wen;
  logic [3:0][4:0] ex_rd;
  logic [3:0][2:0] ex_funct3;
  logic [3:0][`ROB_IDX_W-1:0] ex_rob_index;

  integer seed = 45;
  integer errors = 0;
  integer checks = 0;
  integer tests = 0;
  integer test_mark = 0;
  integer cycles = 0;

  // expected state of the dispatch registers
  logic [3:0] m_ena, m_wen, m_sel;
  logic [3:0][4:0] m_rd;
  logic [3:0][2:0] m_f3;
  logic [3:0][`ROB_IDX_W-1:0] m_rob;
  logic [31:0] m_a, m_b, m_sd;
  alu_op_e m_op;
  logic m_ops_ok, m_op_ok, m_active, m_claims, m_conf, m_disp;
  logic [31:0] booked;
  integer m_delay;
  ref_t r;

  decode_stage DUT (.*);

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] s2, s1,
                                        input logic [2:0] f3, input logic [4:0] d,
                                        input logic [6:0] opc);
    enc_r = {f7, s2, s1, f3, d, opc};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] s1,
                                        input logic [2:0] f3, input logic [4:0] d,
                                        input logic [6:0] opc);
    enc_i = {imm, s1, f3, d, opc};
  endfunction

  function automatic alu_op_e alu_for_funct3(input logic [2:0] f3);
    case (f3)
      3'b000:  alu_for_funct3 = ADD;
      3'b001:  alu_for_funct3 = SLL;
      3'b010:  alu_for_funct3 = SLT;
      3'b011:  alu_for_funct3 = SLTU;
      3'b100:  alu_for_funct3 = XOR;
      3'b101:  alu_for_funct3 = SRL;
      3'b110:  alu_for_funct3 = OR;
      default: alu_for_funct3 = AND;
    endcase
  endfunction

  // expected decode of one instruction with its operand values
  function automatic ref_t ref_decode(input logic [31:0] w, pc_v, r1, r2,
                                      input logic b1e, input logic [31:0] b1d,
                                      input logic b2e, input logic [31:0] b2d);
    ref_t x;
    logic [6:0] f7;
    logic [2:0] f3;
    f7 = w[31:25];
    f3 = w[14:12];
    x = '0;
    x.legal = 1'b1;
    x.unit = FU_ARITH;
    x.op_chk = 1'b1;
    x.op = ADD;
    x.a = b1e ? b1d : r1;
    x.sd = b2e ? b2d : r2;
    x.b = x.sd;
    x.wen = 1'b1;
    case (w[6:0])
      OP: begin
        if (f7 == 7'h01) begin
          x.unit = f3[2] ? FU_DIV : FU_MUL;
          x.op_chk = 1'b0;
        end else if (f7 == 7'h00) x.op = alu_for_funct3(f3);
        else if (f7 == 7'h20 && f3 == 3'b000) x.op = SUB;
        else if (f7 == 7'h20 && f3 == 3'b101) x.op = SRA;
        else x.legal = 1'b0;
      end
      OP_IMM: begin
        x.b = {{20{w[31]}}, w[31:20]};
        x.op = alu_for_funct3(f3);
        if (f3 == 3'b001) x.legal = (f7 == 7'h00);
        if (f3 == 3'b101) begin
          x.op = (f7 == 7'h20) ? SRA : SRL;
          x.legal = (f7 == 7'h00) || (f7 == 7'h20);
        end
      end
      LOAD: begin
        x.unit = FU_LSU;
        x.b = {{20{w[31]}}, w[31:20]};
        x.legal = (f3 <= 3'b010) || (f3 == 3'b100) || (f3 == 3'b101);
      end
      STORE: begin
        x.unit = FU_LSU;
        x.b = {{20{w[31]}}, w[31:25], w[11:7]};
        x.wen = 1'b0;
        x.legal = (f3 <= 3'b010);
      end
      LUI: begin
        x.a = '0;
        x.b = {w[31:12], 12'b0};
      end
      AUIPC: begin
        x.a = pc_v;
        x.b = {w[31:12], 12'b0};
      end
      default: x.legal = 1'b0;
    endcase
    return x;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %08h, expected %08h at %0t", name, got, exp, $time);
    end
  endtask

  // new instruction on the falling edge with all controls back to idle
  task automatic present_ops(input logic [31:0] w, input logic [31:0] a, b);
    @(negedge CLK);
    instr = w;
    pc = pc + 32'd4;
    rs1_data = a;
    rs2_data = b;
    cur_tail = cur_tail + 1'b1;
    rs1_bypass_ena = 1'b0;
    rs2_bypass_ena = 1'b0;
    stall_decode = 1'b0;
    stall_ex = 1'b0;
    fu_stall = '0;
    flush = 1'b0;
  endtask

  task automatic present(input logic [31:0] w);
    present_ops(w, $random(seed), $random(seed));
  endtask

  task automatic finish_test(input string name);
    // let the last instruction reach its register check
    @(posedge CLK);
    #10;
    tests++;
    $display("test %-10s done, %0d errors", name, errors - test_mark);
    test_mark = errors;
  endtask

  // combinational outputs just before the rising edge, registers just after
  initial begin
    forever begin
      @(negedge CLK);
      #45;
      m_active = nRST;
      if (!nRST) begin
        m_ena = '0;
        m_wen = '0;
        booked = '0;
        m_ops_ok = 1'b0;
        m_op_ok = 1'b0;
      end else begin
        r = ref_decode(instr, pc, rs1_data, rs2_data, rs1_bypass_ena, rs1_bypass_data,
                       rs2_bypass_ena, rs2_bypass_data);
        m_claims = r.legal && (r.unit != FU_LSU);
        m_delay = `ALU_WB_SLOT;
        if (r.unit == FU_MUL) m_delay = `MUL_WB_SLOT;
        // special operands finish the divide at once
        if (r.unit == FU_DIV && !((r.a == 32'h8000_0000) || (r.b == '0) || (r.b == '1)))
          m_delay = `DIV_WB_SLOT;
        m_conf = m_claims && booked[m_delay];
        m_disp = r.legal && !stall_decode && !m_conf;
        check("wb_port_conflict", wb_port_conflict, m_conf);
        check("rob_alloc", rob_alloc, m_disp);
        check("rs1", rs1, instr[19:15]);
        check("rs2", rs2, instr[24:20]);
        if (m_disp && m_claims) booked[m_delay] = 1'b1;
        booked = booked >> 1;
        m_sel = m_disp ? (4'b0001 << r.unit) : 4'b0000;
        if (flush) begin
          m_ena = '0;
          m_wen = '0;
          m_a = '0;
          m_b = '0;
          m_sd = '0;
          m_op = ADD;
          m_ops_ok = 1'b1;
          m_op_ok = 1'b1;
        end else if (!stall_ex) begin
          m_a = r.a;
          m_b = r.b;
          m_sd = r.sd;
          m_op = r.op;
          m_ops_ok = r.legal;
          m_op_ok = r.legal && r.op_chk;
          for (int u = 0; u < 4; u++) begin
            if (!fu_stall[u]) begin
              m_ena[u] = m_sel[u];
              m_wen[u] = m_sel[u] && r.wen;
              if (m_sel[u]) begin
                m_rd[u] = instr[11:7];
                m_f3[u] = instr[14:12];
                m_rob[u] = cur_tail;
              end
            end
          end
        end
      end
      @(posedge CLK);
      #5;
      if (m_active) begin
        check("ex_ena", ex_ena, m_ena);
        check("ex_wen", ex_wen, m_wen);
        check("store_data", store_data, m_sd);
        if (m_ops_ok) begin
          check("port_a", port_a, m_a);
          check("port_b", port_b, m_b);
        end
        if (m_op_ok) check("alu_op", alu_op, m_op);
        for (int u = 0; u < 4; u++) begin
          if (m_ena[u]) begin
            check($sformatf("ex_rd[%0d]", u), ex_rd[u], m_rd[u]);
            check($sformatf("ex_funct3[%0d]", u), ex_funct3[u], m_f3[u]);
            check($sformatf("ex_rob_index[%0d]", u), ex_rob_index[u], m_rob[u]);
          end
        end
      end
    end
  end

  initial begin
    nRST = 1'b0;
    instr = '0;
    pc = 32'h0000_1000;
    rs1_data = '0;
    rs2_data = '0;
    rs1_bypass_ena = 1'b0;
    rs1_bypass_data = '0;
    rs2_bypass_ena = 1'b0;
    rs2_bypass_data = '0;
    cur_tail = '0;
    stall_decode = 1'b0;
    stall_ex = 1'b0;
    fu_stall = '0;
    flush = 1'b0;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;

    // register and immediate arithmetic, lui, auipc
    present(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, OP));
    present(enc_r(7'h20, 5'd4, 5'd5, 3'b000, 5'd6, OP));
    present(enc_r(7'h00, 5'd7, 5'd8, 3'b011, 5'd9, OP));
    present(enc_i(12'hf85, 5'd10, 3'b000, 5'd11, OP_IMM));
    present(enc_i(12'h407, 5'd12, 3'b101, 5'd13, OP_IMM));
    present({20'habcde, 5'd14, LUI});
    present({20'h12345, 5'd15, AUIPC});
    finish_test("arith");

    // bypass on both sources, then a store carrying the bypassed rs2
    present(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd3, OP));
    rs1_bypass_ena = 1'b1;
    rs1_bypass_data = $random(seed);
    rs2_bypass_ena = 1'b1;
    rs2_bypass_data = $random(seed);
    present(enc_r(7'h15, 5'd9, 5'd4, 3'b010, 5'h1c, STORE));
    rs2_bypass_ena = 1'b1;
    rs2_bypass_data = $random(seed);
    finish_test("bypass");

    // mul, rem, a special divide, then arith on the write cycle of the mul
    present(enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd3, OP));
    present_ops(enc_r(7'h01, 5'd2, 5'd1, 3'b110, 5'd4, OP), 32'd99, 32'd5);
    present_ops(enc_r(7'h01, 5'd2, 5'd1, 3'b100, 5'd5, OP), 32'd7, 32'd0);
    present(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd6, OP));
    repeat (14) present(32'h0);
    // rem result lands here, the special divide left this cycle free
    present(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd7, OP));
    present(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd8, OP));
    repeat (2) present(32'h0);
    finish_test("muldiv");

    // write port collisions at distance 3 and 17 with passing neighbours
    present(enc_r(7'h01, 5'd2, 5'd1, 3'b001, 5'd3, OP));
    present(32'h0);
    present(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd4, OP));
    present(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd5, OP));
    present(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd6, OP));
    present_ops(enc_r(7'h01, 5'd2, 5'd1, 3'b101, 5'd7, OP), 32'd1000, 32'd3);
    repeat (15) present(32'h0);
    present(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd8, OP));
    present(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd9, OP));
    present(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd10, OP));
    finish_test("conflict");

    // flush, global stall, one unit stalled, decode stall
    present(enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd3, OP));
    present(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd4, OP));
    flush = 1'b1;
    present(enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd5, OP));
    present(enc_r(7'h00, 5'd2, 5'd1, 3'b001, 5'd6, OP));
    stall_ex = 1'b1;
    present(enc_i(12'h010, 5'd1, 3'b010, 5'd7, LOAD));
    stall_ex = 1'b1;
    present(enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd8, OP));
    present(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd9, OP));
    fu_stall = 4'b0010;
    present(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd10, OP));
    stall_decode = 1'b1;
    present(32'h0);
    finish_test("control");

    // loads, stores and an illegal word
    present(enc_i(12'h7fc, 5'd3, 3'b100, 5'd11, LOAD));
    present(enc_r(7'h7f, 5'd6, 5'd2, 3'b001, 5'h08, STORE));
    present(enc_r(7'h7f, 5'd2, 5'd1, 3'b000, 5'd12, OP));
    present(enc_i(12'h001, 5'd3, 3'b111, 5'd13, LOAD));
    present(32'h0);
    present(32'h0);
    finish_test("lsu");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
